/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_axi_mem_subsys
FLIST     ?= axi_mem_subsys.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(BUILD_DIR)

/* axi_mem_subsys.f */
verilog/axi_sub_pkg.sv
verilog/axi_bus_if.sv
verilog/burst_master.sv
verilog/axi_arbiter.sv
verilog/axi_sram_slave.sv
verilog/axi_protocol_checker.sv
verilog/axi_mem_subsys.sv
dv/axi_arbiter_assert.sv
dv/tb_axi_mem_subsys.sv

/* dv/axi_arbiter_assert.sv */
`timescale 1ns/1ps
module axi_arbiter_assert (
    input logic inf,
    input logic arst_n,
    input logic busy,
    input logic owner,
    input logic txn_end,
    input logic m0_awvalid,
    input logic m0_arvalid,
    input logic m1_awvalid,
    input logic m1_arvalid
);

    int   failures = 0;
    logic m0_req;
    logic m1_req;

    assign m0_req = m0_awvalid || m0_arvalid;
    assign m1_req = m1_awvalid || m1_arvalid;

    // grant holds for the whole transaction
    owner_stable: assert property (@(posedge inf) disable iff (!arst_n)
        (busy && !txn_end) |=> $stable(owner))
        else begin
            $error("arbiter owner changed while busy");
            failures++;
        end

    // a fresh grant lands only on a master with a pending command
    grant_to_requester: assert property (@(posedge inf) disable iff (!arst_n)
        (busy && (!$past(busy) || $past(txn_end))) |-> (owner ? m1_req : m0_req))
        else begin
            $error("arbiter granted a master without a request");
            failures++;
        end

    // a master without the grant sees no ready, so its command stays up
    m0_waits: assert property (@(posedge inf) disable iff (!arst_n)
        (m0_req && !(busy && !owner)) |=> m0_req)
        else begin
            $error("master 0 command accepted while not owner");
            failures++;
        end

    m1_waits: assert property (@(posedge inf) disable iff (!arst_n)
        (m1_req && !(busy && owner)) |=> m1_req)
        else begin
            $error("master 1 command accepted while not owner");
            failures++;
        end

endmodule

bind axi_arbiter axi_arbiter_assert i_axi_arbiter_assert (
    .inf        (inf),
    .arst_n     (arst_n),
    .busy       (busy),
    .owner      (owner),
    .txn_end    (txn_end),
    .m0_awvalid (m0.awvalid),
    .m0_arvalid (m0.arvalid),
    .m1_awvalid (m1.awvalid),
    .m1_arvalid (m1.arvalid)
);

/* dv/tb_axi_mem_subsys.sv */
`timescale 1ns/1ps
module tb_axi_mem_subsys import axi_sub_pkg::*; ();

    localparam int half_period  = 20;
    localparam int drive_delay  = 2;
    localparam int reset_cycles = 16;
    localparam int rounds       = 20;
    localparam int stall_cycles = 100;
    // 40 bursts per requester, 16 beats, 4 cycles per beat, plus the stall tests
    localparam int cycle_limit  = 40 * 16 * 4 + 2 * (stall_cycles + timeout_cycles) + 2000;

    logic              inf;
    logic              arst_n;
    logic              cmd_valid [2];
    logic              cmd_ready [2];
    logic              cmd_write [2];
    logic [addr_w-1:0] cmd_addr [2];
    logic [len_w-1:0]  cmd_len [2];
    logic              wdata_valid [2];
    logic              wdata_ready [2];
    logic [data_w-1:0] wdata [2];
    logic              wdone [2];
    logic              rdata_valid [2];
    logic              rdata_ready [2];
    logic [data_w-1:0] rdata [2];
    logic              rdata_last [2];
    logic              wr_err_valid;
    err_phase_t        wr_err_phase;
    logic              rd_err_valid;
    err_phase_t        rd_err_phase;

    // expected memory contents
    logic [data_w-1:0] model [mem_words];

    int         seed = 59882;
    int         value_errors;
    int         other_errors;
    int         cycles;
    int         wdone_cnt [2];
    int         writes_done [2];
    int         wr_err_cnt;
    int         rd_err_cnt;
    err_phase_t wr_err_last;
    err_phase_t rd_err_last;

    axi_mem_subsys i_axi_mem_subsys (
        .inf            (inf),
        .arst_n         (arst_n),
        .r0_cmd_valid   (cmd_valid[0]),
        .r0_cmd_ready   (cmd_ready[0]),
        .r0_cmd_write   (cmd_write[0]),
        .r0_cmd_addr    (cmd_addr[0]),
        .r0_cmd_len     (cmd_len[0]),
        .r0_wdata_valid (wdata_valid[0]),
        .r0_wdata_ready (wdata_ready[0]),
        .r0_wdata       (wdata[0]),
        .r0_wdone       (wdone[0]),
        .r0_rdata_valid (rdata_valid[0]),
        .r0_rdata_ready (rdata_ready[0]),
        .r0_rdata       (rdata[0]),
        .r0_rdata_last  (rdata_last[0]),
        .r1_cmd_valid   (cmd_valid[1]),
        .r1_cmd_ready   (cmd_ready[1]),
        .r1_cmd_write   (cmd_write[1]),
        .r1_cmd_addr    (cmd_addr[1]),
        .r1_cmd_len     (cmd_len[1]),
        .r1_wdata_valid (wdata_valid[1]),
        .r1_wdata_ready (wdata_ready[1]),
        .r1_wdata       (wdata[1]),
        .r1_wdone       (wdone[1]),
        .r1_rdata_valid (rdata_valid[1]),
        .r1_rdata_ready (rdata_ready[1]),
        .r1_rdata       (rdata[1]),
        .r1_rdata_last  (rdata_last[1]),
        .wr_err_valid   (wr_err_valid),
        .wr_err_phase   (wr_err_phase),
        .rd_err_valid   (rd_err_valid),
        .rd_err_phase   (rd_err_phase)
    );

    initial inf = 1'b0;
    always #half_period inf = ~inf;

    // outputs are sampled mid-cycle, away from the drive edge
    always @(negedge inf) begin
        if (arst_n) begin
            for (int k = 0; k < 2; k++) begin
                if (wdone[k]) begin
                    wdone_cnt[k]++;
                end
            end
            if (wr_err_valid) begin
                wr_err_cnt++;
                wr_err_last = wr_err_phase;
            end
            if (rd_err_valid) begin
                rd_err_cnt++;
                rd_err_last = rd_err_phase;
            end
        end
    end

    always @(posedge inf) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            other_errors++;
            $display("errors: value=%0d other=%0d assert=%0d", value_errors, other_errors,
                     i_axi_mem_subsys.i_axi_arbiter.i_axi_arbiter_assert.failures);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    function automatic int rnd(int n);
        rnd = {$random(seed)} % n;
    endfunction

    task automatic check_value(string name, longint expected, longint observed);
        if (expected != observed) begin
            $display("CHECK FAILED t=%0t %s expected=%0h observed=%0h",
                     $time, name, expected, observed);
            value_errors++;
        end
    endtask

    task automatic next_cycle();
        @(posedge inf);
        #drive_delay;
    endtask

    task automatic issue_cmd(int k, bit wr, int addr, int len);
        cmd_valid[k] = 1'b1;
        cmd_write[k] = wr;
        cmd_addr[k]  = addr[addr_w-1:0];
        cmd_len[k]   = len[len_w-1:0];
        @(negedge inf);
        while (!cmd_ready[k]) @(negedge inf);
        next_cycle();
        cmd_valid[k] = 1'b0;
    endtask

    task automatic write_burst(int k, int addr, int len, int hold);
        logic [data_w-1:0] d;
        issue_cmd(k, 1'b1, addr, len);
        repeat (hold) next_cycle();
        for (int b = 0; b <= len; b++) begin
            if (rnd(4) == 0) begin
                repeat (rnd(3)) next_cycle();
            end
            d = $random(seed);
            wdata[k]       = d;
            wdata_valid[k] = 1'b1;
            forever begin
                @(negedge inf);
                if (wdone[k]) begin
                    $display("t=%0t requester %0d: write done before all beats", $time, k);
                    other_errors++;
                end
                if (wdata_ready[k]) break;
            end
            model[addr + b] = d;
            next_cycle();
            wdata_valid[k] = 1'b0;
        end
        @(negedge inf);
        while (!wdone[k]) @(negedge inf);
        writes_done[k]++;
        next_cycle();
        check_value($sformatf("r%0d_wdone count", k), writes_done[k], wdone_cnt[k]);
    endtask

    task automatic read_burst(int k, int addr, int len, int stall_beat);
        issue_cmd(k, 1'b0, addr, len);
        for (int b = 0; b <= len; b++) begin
            if (b == stall_beat) begin
                rdata_ready[k] = 1'b0;
                repeat (stall_cycles) next_cycle();
            end else if (rnd(4) == 0) begin
                rdata_ready[k] = 1'b0;
                repeat (rnd(3) + 1) next_cycle();
            end
            rdata_ready[k] = 1'b1;
            @(negedge inf);
            while (!rdata_valid[k]) @(negedge inf);
            check_value($sformatf("r%0d_rdata", k), model[addr + b], rdata[k]);
            check_value($sformatf("r%0d_rdata_last", k), (b == len), rdata_last[k]);
            next_cycle();
        end
        rdata_ready[k] = 1'b0;
    endtask

    // each requester stays inside its own half of the memory
    task automatic run_requester(int k);
        int len;
        int addr;
        for (int i = 0; i < rounds; i++) begin
            len  = rnd(16);
            addr = k * 128 + rnd(128 - len);
            write_burst(k, addr, len, 0);
            repeat (rnd(3)) next_cycle();
            read_burst(k, addr, len, -1);
        end
    endtask

    initial begin
        arst_n = 1'b0;
        for (int k = 0; k < 2; k++) begin
            cmd_valid[k]   = 1'b0;
            cmd_write[k]   = 1'b0;
            cmd_addr[k]    = '0;
            cmd_len[k]     = '0;
            wdata_valid[k] = 1'b0;
            wdata[k]       = '0;
            rdata_ready[k] = 1'b0;
        end
        repeat (reset_cycles) @(posedge inf);
        #drive_delay;
        arst_n = 1'b1;
        next_cycle();

        fork
            run_requester(0);
            run_requester(1);
        join
        repeat (4) next_cycle();
        check_value("wr_err_valid pulses", 0, wr_err_cnt);
        check_value("rd_err_valid pulses", 0, rd_err_cnt);

        // write data held back past the stall limit
        write_burst(0, 16, 7, stall_cycles);
        repeat (4) next_cycle();
        check_value("wr_err_valid pulses", 1, wr_err_cnt);
        check_value("wr_err_phase", ph_data, wr_err_last);
        read_burst(0, 16, 7, -1);

        // read ready held low in the middle of a burst
        write_burst(1, 200, 15, 0);
        read_burst(1, 200, 15, 8);
        repeat (4) next_cycle();
        check_value("rd_err_valid pulses", 1, rd_err_cnt);
        check_value("rd_err_phase", ph_data, rd_err_last);
        check_value("wr_err_valid pulses", 1, wr_err_cnt);

        // one done pulse per write over the whole run
        for (int k = 0; k < 2; k++) begin
            check_value($sformatf("r%0d_wdone count", k), writes_done[k], wdone_cnt[k]);
        end

        $display("errors: value=%0d other=%0d assert=%0d", value_errors, other_errors,
                 i_axi_mem_subsys.i_axi_arbiter.i_axi_arbiter_assert.failures);
        if (value_errors + other_errors
            + i_axi_mem_subsys.i_axi_arbiter.i_axi_arbiter_assert.failures == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* verilog/axi_arbiter.sv */
`timescale 1ns/1ps
module axi_arbiter (
    input  logic      inf,
    input  logic      arst_n,
    axi_bus_if.slave  m0,
    axi_bus_if.slave  m1,
    axi_bus_if.master s
);

    logic busy;
    logic owner;
    logic req0;
    logic req1;
    logic txn_end;
    logic next_owner;
    logic g0;
    logic g1;

    assign req0 = m0.awvalid || m0.arvalid;
    assign req1 = m1.awvalid || m1.arvalid;

    // a transaction ends on b, or on the last r beat
    assign txn_end = (s.bvalid && s.bready) || (s.rvalid && s.rready && s.rlast);

    // owner doubles as the round-robin pointer, the other master goes first
    assign next_owner = owner ? !req0 : req1;

    always_ff @(posedge inf or negedge arst_n) begin
        if (!arst_n) begin
            busy  <= 1'b0;
            owner <= 1'b0;
        end else if (!busy || txn_end) begin
            // the finishing owner has no request left, so a pending peer wins
            busy <= req0 || req1;
            if (req0 || req1) begin
                owner <= next_owner;
            end
        end
    end

    assign g0 = busy && !owner;
    assign g1 = busy && owner;

    // owner side onto the slave bus
    assign s.awvalid = (g0 && m0.awvalid) || (g1 && m1.awvalid);
    assign s.awaddr  = owner ? m1.awaddr : m0.awaddr;
    assign s.awlen   = owner ? m1.awlen : m0.awlen;
    assign s.wvalid  = (g0 && m0.wvalid) || (g1 && m1.wvalid);
    assign s.wdata   = owner ? m1.wdata : m0.wdata;
    assign s.wlast   = owner ? m1.wlast : m0.wlast;
    assign s.bready  = (g0 && m0.bready) || (g1 && m1.bready);
    assign s.arvalid = (g0 && m0.arvalid) || (g1 && m1.arvalid);
    assign s.araddr  = owner ? m1.araddr : m0.araddr;
    assign s.arlen   = owner ? m1.arlen : m0.arlen;
    assign s.rready  = (g0 && m0.rready) || (g1 && m1.rready);

    // slave responses go back to the owner only
    assign m0.awready = g0 && s.awready;
    assign m0.wready  = g0 && s.wready;
    assign m0.bvalid  = g0 && s.bvalid;
    assign m0.arready = g0 && s.arready;
    assign m0.rvalid  = g0 && s.rvalid;
    assign m0.rdata   = s.rdata;
    assign m0.rlast   = s.rlast;

    assign m1.awready = g1 && s.awready;
    assign m1.wready  = g1 && s.wready;
    assign m1.bvalid  = g1 && s.bvalid;
    assign m1.arready = g1 && s.arready;
    assign m1.rvalid  = g1 && s.rvalid;
    assign m1.rdata   = s.rdata;
    assign m1.rlast   = s.rlast;

endmodule

/* verilog/axi_bus_if.sv */
`timescale 1ns/1ps
interface axi_bus_if import axi_sub_pkg::*; ();

    // write address
    logic              awvalid;
    logic              awready;
    logic [addr_w-1:0] awaddr;
    logic [len_w-1:0]  awlen;
    // write data
    logic              wvalid;
    logic              wready;
    logic [data_w-1:0] wdata;
    logic              wlast;
    // write response
    logic              bvalid;
    logic              bready;
    // read address
    logic              arvalid;
    logic              arready;
    logic [addr_w-1:0] araddr;
    logic [len_w-1:0]  arlen;
    // read data
    logic              rvalid;
    logic              rready;
    logic [data_w-1:0] rdata;
    logic              rlast;

    modport master (
        output awvalid, awaddr, awlen, wvalid, wdata, wlast, bready,
        output arvalid, araddr, arlen, rready,
        input  awready, wready, bvalid, arready, rvalid, rdata, rlast
    );

    modport slave (
        input  awvalid, awaddr, awlen, wvalid, wdata, wlast, bready,
        input  arvalid, araddr, arlen, rready,
        output awready, wready, bvalid, arready, rvalid, rdata, rlast
    );

    modport monitor (
        input awvalid, awready, awaddr, awlen, wvalid, wready, wdata, wlast,
        input bvalid, bready, arvalid, arready, araddr, arlen,
        input rvalid, rready, rdata, rlast
    );

endinterface

/* verilog/axi_mem_subsys.sv */
`timescale 1ns/1ps
module axi_mem_subsys import axi_sub_pkg::*; (
    input  logic              inf,
    input  logic              arst_n,
    // requester 0
    input  logic              r0_cmd_valid,
    output logic              r0_cmd_ready,
    input  logic              r0_cmd_write,
    input  logic [addr_w-1:0] r0_cmd_addr,
    input  logic [len_w-1:0]  r0_cmd_len,
    input  logic              r0_wdata_valid,
    output logic              r0_wdata_ready,
    input  logic [data_w-1:0] r0_wdata,
    output logic              r0_wdone,
    output logic              r0_rdata_valid,
    input  logic              r0_rdata_ready,
    output logic [data_w-1:0] r0_rdata,
    output logic              r0_rdata_last,
    // requester 1
    input  logic              r1_cmd_valid,
    output logic              r1_cmd_ready,
    input  logic              r1_cmd_write,
    input  logic [addr_w-1:0] r1_cmd_addr,
    input  logic [len_w-1:0]  r1_cmd_len,
    input  logic              r1_wdata_valid,
    output logic              r1_wdata_ready,
    input  logic [data_w-1:0] r1_wdata,
    output logic              r1_wdone,
    output logic              r1_rdata_valid,
    input  logic              r1_rdata_ready,
    output logic [data_w-1:0] r1_rdata,
    output logic              r1_rdata_last,
    // checker
    output logic              wr_err_valid,
    output err_phase_t        wr_err_phase,
    output logic              rd_err_valid,
    output err_phase_t        rd_err_phase
);

    axi_bus_if m0_bus ();
    axi_bus_if m1_bus ();
    axi_bus_if s_bus ();

    burst_master i_burst_master_0 (
        .inf         (inf),
        .arst_n      (arst_n),
        .cmd_valid   (r0_cmd_valid),
        .cmd_ready   (r0_cmd_ready),
        .cmd_write   (r0_cmd_write),
        .cmd_addr    (r0_cmd_addr),
        .cmd_len     (r0_cmd_len),
        .wdata_valid (r0_wdata_valid),
        .wdata_ready (r0_wdata_ready),
        .wdata       (r0_wdata),
        .wdone       (r0_wdone),
        .rdata_valid (r0_rdata_valid),
        .rdata_ready (r0_rdata_ready),
        .rdata       (r0_rdata),
        .rdata_last  (r0_rdata_last),
        .bus         (m0_bus.master)
    );

    burst_master i_burst_master_1 (
        .inf         (inf),
        .arst_n      (arst_n),
        .cmd_valid   (r1_cmd_valid),
        .cmd_ready   (r1_cmd_ready),
        .cmd_write   (r1_cmd_write),
        .cmd_addr    (r1_cmd_addr),
        .cmd_len     (r1_cmd_len),
        .wdata_valid (r1_wdata_valid),
        .wdata_ready (r1_wdata_ready),
        .wdata       (r1_wdata),
        .wdone       (r1_wdone),
        .rdata_valid (r1_rdata_valid),
        .rdata_ready (r1_rdata_ready),
        .rdata       (r1_rdata),
        .rdata_last  (r1_rdata_last),
        .bus         (m1_bus.master)
    );

    axi_arbiter i_axi_arbiter (
        .inf    (inf),
        .arst_n (arst_n),
        .m0     (m0_bus.slave),
        .m1     (m1_bus.slave),
        .s      (s_bus.master)
    );

    axi_sram_slave i_axi_sram_slave (
        .inf    (inf),
        .arst_n (arst_n),
        .bus    (s_bus.slave)
    );

    // watches the shared bus only
    axi_protocol_checker i_axi_protocol_checker (
        .inf          (inf),
        .arst_n       (arst_n),
        .bus          (s_bus.monitor),
        .wr_err_valid (wr_err_valid),
        .wr_err_phase (wr_err_phase),
        .rd_err_valid (rd_err_valid),
        .rd_err_phase (rd_err_phase)
    );

endmodule

/* verilog/axi_protocol_checker.sv */
`timescale 1ns/1ps
module axi_protocol_checker import axi_sub_pkg::*; (
    input  logic       inf,
    input  logic       arst_n,
    axi_bus_if.monitor bus,
    output logic       wr_err_valid,
    output err_phase_t wr_err_phase,
    output logic       rd_err_valid,
    output err_phase_t rd_err_phase
);

    logic aw_hs;
    logic w_hs;
    logic b_hs;
    logic ar_hs;
    logic r_hs;

    // each FSM state is the phase it reports
    err_phase_t         wr_st;
    err_phase_t         rd_st;
    logic [len_w-1:0]   wr_len;
    logic [len_w-1:0]   rd_len;
    logic [len_w:0]     wr_beats;
    logic [len_w:0]     rd_beats;
    logic [stall_w-1:0] wr_stall;
    logic [stall_w-1:0] rd_stall;
    logic               wr_viol;
    logic               rd_viol;
    err_phase_t         wr_viol_ph;
    err_phase_t         rd_viol_ph;
    logic               wr_viol_q;
    logic               rd_viol_q;
    err_phase_t         wr_ph_q;
    err_phase_t         rd_ph_q;

    assign aw_hs = bus.awvalid && bus.awready;
    assign w_hs  = bus.wvalid && bus.wready;
    assign b_hs  = bus.bvalid && bus.bready;
    assign ar_hs = bus.arvalid && bus.arready;
    assign r_hs  = bus.rvalid && bus.rready;

    // waiting on the first write beat counts as the data phase
    always_ff @(posedge inf or negedge arst_n) begin
        if (!arst_n) begin
            wr_st    <= ph_idle;
            wr_beats <= '0;
            wr_stall <= '0;
        end else begin
            case (wr_st)
                ph_idle:     wr_st <= aw_hs ? ph_data : (bus.awvalid ? ph_cmd_wait : ph_idle);
                ph_cmd_wait: wr_st <= aw_hs ? ph_data : ph_cmd_wait;
                ph_data:     wr_st <= (w_hs && bus.wlast) ? ph_resp : ph_data;
                ph_resp:     wr_st <= b_hs ? ph_idle : ph_resp;
                default:     wr_st <= ph_idle;
            endcase
            if (aw_hs) begin
                wr_beats <= '0;
            end else if (w_hs) begin
                wr_beats <= wr_beats + 1'b1;
            end
            // restarts on every beat, saturates at the limit
            if (wr_st == ph_idle || aw_hs || w_hs || b_hs) begin
                wr_stall <= '0;
            end else if (wr_stall != stall_w'(timeout_cycles)) begin
                wr_stall <= wr_stall + 1'b1;
            end
        end
    end

    always_ff @(posedge inf or negedge arst_n) begin
        if (!arst_n) begin
            rd_st    <= ph_idle;
            rd_beats <= '0;
            rd_stall <= '0;
        end else begin
            case (rd_st)
                ph_idle:     rd_st <= ar_hs ? ph_data : (bus.arvalid ? ph_cmd_wait : ph_idle);
                ph_cmd_wait: rd_st <= ar_hs ? ph_data : ph_cmd_wait;
                ph_data:     rd_st <= (r_hs && bus.rlast) ? ph_idle : ph_data;
                default:     rd_st <= ph_idle;
            endcase
            if (ar_hs) begin
                rd_beats <= '0;
            end else if (r_hs) begin
                rd_beats <= rd_beats + 1'b1;
            end
            if (rd_st == ph_idle || ar_hs || r_hs) begin
                rd_stall <= '0;
            end else if (rd_stall != stall_w'(timeout_cycles)) begin
                rd_stall <= rd_stall + 1'b1;
            end
        end
    end

    always_ff @(posedge inf) begin
        if (aw_hs) begin
            wr_len <= bus.awlen;
        end
        if (ar_hs) begin
            rd_len <= bus.arlen;
        end
    end

    // command overlap first, then beat count, then stall
    always_comb begin
        wr_viol    = 1'b0;
        wr_viol_ph = wr_st;
        if (aw_hs && (wr_st == ph_data || wr_st == ph_resp)) begin
            wr_viol    = 1'b1;
            wr_viol_ph = ph_cmd_wait;
        end else if (w_hs && bus.wlast && wr_beats != {1'b0, wr_len}) begin
            wr_viol    = 1'b1;
            wr_viol_ph = ph_beat_count;
        end else if (wr_st != ph_idle && !(aw_hs || w_hs || b_hs)
                     && wr_stall == stall_w'(timeout_cycles - 1)) begin
            wr_viol = 1'b1;
        end
    end

    always_comb begin
        rd_viol    = 1'b0;
        rd_viol_ph = rd_st;
        if (ar_hs && rd_st == ph_data) begin
            rd_viol    = 1'b1;
            rd_viol_ph = ph_cmd_wait;
        end else if (r_hs && bus.rlast && rd_beats != {1'b0, rd_len}) begin
            rd_viol    = 1'b1;
            rd_viol_ph = ph_beat_count;
        end else if (rd_st != ph_idle && !(ar_hs || r_hs)
                     && rd_stall == stall_w'(timeout_cycles - 1)) begin
            rd_viol = 1'b1;
        end
    end

    // two register stages to the error outputs
    always_ff @(posedge inf or negedge arst_n) begin
        if (!arst_n) begin
            wr_viol_q    <= 1'b0;
            rd_viol_q    <= 1'b0;
            wr_err_valid <= 1'b0;
            rd_err_valid <= 1'b0;
        end else begin
            wr_viol_q    <= wr_viol;
            rd_viol_q    <= rd_viol;
            wr_err_valid <= wr_viol_q;
            rd_err_valid <= rd_viol_q;
        end
    end

    always_ff @(posedge inf) begin
        wr_ph_q      <= wr_viol_ph;
        rd_ph_q      <= rd_viol_ph;
        wr_err_phase <= wr_ph_q;
        rd_err_phase <= rd_ph_q;
    end

endmodule

/* verilog/axi_sram_slave.sv */
`timescale 1ns/1ps
module axi_sram_slave import axi_sub_pkg::*; (
    input  logic     inf,
    input  logic     arst_n,
    axi_bus_if.slave bus
);

    typedef enum logic [1:0] {
        st_idle,
        st_w,
        st_b,
        st_r
    } state_t;

    state_t            state;
    logic [data_w-1:0] mem [mem_words];
    logic [addr_w-1:0] addr_q;
    logic [len_w-1:0]  len_q;
    logic [len_w-1:0]  beat_q;
    logic              aw_hs;
    logic              ar_hs;
    logic              w_hs;
    logic              r_hs;

    // writes win a same-cycle tie
    assign bus.awready = (state == st_idle);
    assign bus.arready = (state == st_idle) && !bus.awvalid;
    assign bus.wready  = (state == st_w);
    assign bus.bvalid  = (state == st_b);
    assign bus.rvalid  = (state == st_r);
    assign bus.rdata   = mem[addr_q];
    assign bus.rlast   = (beat_q == len_q);

    assign aw_hs = bus.awvalid && bus.awready;
    assign ar_hs = bus.arvalid && bus.arready;
    assign w_hs  = bus.wvalid && bus.wready;
    assign r_hs  = bus.rvalid && bus.rready;

    // burst address walks up one word per beat
    always_ff @(posedge inf) begin
        if (aw_hs) begin
            addr_q <= bus.awaddr;
        end else if (ar_hs) begin
            addr_q <= bus.araddr;
            len_q  <= bus.arlen;
        end else if (w_hs || r_hs) begin
            addr_q <= addr_q + 1'b1;
        end
        if (w_hs) begin
            mem[addr_q] <= bus.wdata;
        end
    end

    always_ff @(posedge inf or negedge arst_n) begin
        if (!arst_n) begin
            state  <= st_idle;
            beat_q <= '0;
        end else begin
            case (state)
                st_idle: begin
                    beat_q <= '0;
                    if (aw_hs) begin
                        state <= st_w;
                    end else if (ar_hs) begin
                        state <= st_r;
                    end
                end
                st_w: begin
                    if (w_hs && bus.wlast) begin
                        state <= st_b;
                    end
                end
                st_b: begin
                    if (bus.bready) begin
                        state <= st_idle;
                    end
                end
                st_r: begin
                    if (r_hs) begin
                        beat_q <= beat_q + 1'b1;
                        if (bus.rlast) begin
                            state <= st_idle;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

/* verilog/axi_sub_pkg.sv */
package axi_sub_pkg;

    // bus geometry
    localparam int addr_w = 8;
    localparam int data_w = 32;
    // length field holds beats minus one
    localparam int len_w = 4;
    localparam int mem_words = 256;

    // checker stall limit, cycles without a beat
    localparam int timeout_cycles = 64;
    // one extra bit so the stall counter can sit at the limit
    localparam int stall_w = $clog2(timeout_cycles) + 1;

    // phase reported with a checker error
    typedef enum logic [2:0] {
        ph_idle       = 3'd0,
        ph_cmd_wait   = 3'd1,
        ph_data       = 3'd2,
        ph_resp       = 3'd3,
        ph_beat_count = 3'd4
    } err_phase_t;

endpackage

/* verilog/burst_master.sv */
`timescale 1ns/1ps
module burst_master import axi_sub_pkg::*; (
    input  logic              inf,
    input  logic              arst_n,
    input  logic              cmd_valid,
    output logic              cmd_ready,
    input  logic              cmd_write,
    input  logic [addr_w-1:0] cmd_addr,
    input  logic [len_w-1:0]  cmd_len,
    input  logic              wdata_valid,
    output logic              wdata_ready,
    input  logic [data_w-1:0] wdata,
    output logic              wdone,
    output logic              rdata_valid,
    input  logic              rdata_ready,
    output logic [data_w-1:0] rdata,
    output logic              rdata_last,
    axi_bus_if.master         bus
);

    typedef enum logic [2:0] {
        st_idle,
        st_aw,
        st_w,
        st_b,
        st_ar,
        st_r
    } state_t;

    state_t            state;
    logic [addr_w-1:0] addr_q;
    logic [len_w-1:0]  len_q;
    logic [len_w-1:0]  beat_q;

    // one transaction at a time
    assign cmd_ready = (state == st_idle);

    assign bus.awvalid = (state == st_aw);
    assign bus.awaddr  = addr_q;
    assign bus.awlen   = len_q;
    assign bus.arvalid = (state == st_ar);
    assign bus.araddr  = addr_q;
    assign bus.arlen   = len_q;

    // requester write stream goes straight onto w
    assign bus.wvalid  = (state == st_w) && wdata_valid;
    assign bus.wdata   = wdata;
    assign bus.wlast   = (beat_q == len_q);
    assign wdata_ready = (state == st_w) && bus.wready;

    // b handshake becomes the done pulse
    assign bus.bready = (state == st_b);
    assign wdone      = (state == st_b) && bus.bvalid;

    assign rdata_valid = (state == st_r) && bus.rvalid;
    assign rdata       = bus.rdata;
    assign rdata_last  = bus.rlast;
    assign bus.rready  = (state == st_r) && rdata_ready;

    always_ff @(posedge inf) begin
        if (cmd_valid && cmd_ready) begin
            addr_q <= cmd_addr;
            len_q  <= cmd_len;
        end
    end

    always_ff @(posedge inf or negedge arst_n) begin
        if (!arst_n) begin
            state  <= st_idle;
            beat_q <= '0;
        end else begin
            case (state)
                st_idle: begin
                    beat_q <= '0;
                    if (cmd_valid) begin
                        state <= cmd_write ? st_aw : st_ar;
                    end
                end
                st_aw: begin
                    if (bus.awready) begin
                        state <= st_w;
                    end
                end
                st_w: begin
                    if (bus.wvalid && bus.wready) begin
                        beat_q <= beat_q + 1'b1;
                        if (bus.wlast) begin
                            state <= st_b;
                        end
                    end
                end
                st_b: begin
                    if (bus.bvalid) begin
                        state <= st_idle;
                    end
                end
                st_ar: begin
                    if (bus.arready) begin
                        state <= st_r;
                    end
                end
                st_r: begin
                    if (bus.rvalid && bus.rready && bus.rlast) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule
